// File: Makefile
VERILATOR  ?= verilator
TOP        ?= tb_sdram_ctrl
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Simulation failed" $(LOG); then \
		echo "run failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/bank_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module bank_tracker (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire sdram_pkg::bank_t query_bank,
    input  wire sdram_pkg::row_t  query_row,
    output logic                  row_open,
    output logic                  row_hit,
    input  wire logic             act_stb,
    input  wire sdram_pkg::bank_t act_bank,
    input  wire sdram_pkg::row_t  act_row,
    input  wire logic             pre_stb,
    input  wire sdram_pkg::bank_t pre_bank,
    input  wire logic             pre_all
);

    localparam int NUM_BANKS = 2 ** $bits(sdram_pkg::bank_t);

    logic [NUM_BANKS-1:0] open_q;
    sdram_pkg::row_t      open_row [NUM_BANKS];

    always_ff @(posedge clk) begin
        if (rst) begin
            open_q <= '0;
        end else if (pre_all) begin
            open_q <= '0;
        end else begin
            if (pre_stb) open_q[pre_bank] <= 1'b0;
            if (act_stb) open_q[act_bank] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (act_stb) open_row[act_bank] <= act_row;
    end

    assign row_open = open_q[query_bank];
    assign row_hit  = open_q[query_bank] && (open_row[query_bank] == query_row);

endmodule

`default_nettype wire

// File: design/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

    typedef logic [22:0] user_addr_t;  // as presented by the user
    typedef logic [22:0] mem_addr_t;   // {row, bank, col}

    typedef enum logic [2:0] {
        IDLE,
        WAIT,
        REFRESH,
        ACTIVATE,
        PRECHARGE,
        READ,
        WRITE
    } ctrl_state_t;

    ////////////////////
    // prefetch line

    localparam int LINE_WORDS = 8;

    typedef logic [2:0]  line_idx_t;   // low column bits
    typedef logic [19:0] line_tag_t;   // mem addr without line_idx

endpackage

`default_nettype wire

// File: design/prefetch_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module prefetch_buffer (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire ctrl_pkg::mem_addr_t look_addr,
    output logic                     buf_hit,
    output sdram_pkg::word_t         buf_word,
    input  wire logic                line_start,
    input  wire ctrl_pkg::line_tag_t line_tag,
    input  wire logic                fill_stb,
    input  wire ctrl_pkg::line_idx_t fill_idx,
    input  wire sdram_pkg::word_t    fill_word,
    input  wire logic                line_done,
    input  wire logic                inval
);

    sdram_pkg::word_t    words [ctrl_pkg::LINE_WORDS];
    ctrl_pkg::line_tag_t tag_q;
    logic                valid_q;

    ctrl_pkg::line_tag_t look_tag;
    ctrl_pkg::line_idx_t look_idx;

    assign look_tag = look_addr[22:3];
    assign look_idx = look_addr[2:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (inval || line_start) begin
            valid_q <= 1'b0;  // invalidate wins over a finishing fill
        end else if (line_done) begin
            valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (line_start) tag_q <= line_tag;
        if (fill_stb) words[fill_idx] <= fill_word;
    end

    assign buf_hit  = valid_q && (tag_q == look_tag);
    assign buf_word = words[look_idx];  // also read on a miss, for the fill bypass

endmodule

`default_nettype wire

// File: design/refresh_timer.sv
`timescale 1ns/1ps
`default_nettype none

module refresh_timer #(
    parameter int refresh_interval = 750
) (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic refresh_ack,
    output logic      refresh_due
);

    localparam int CNT_W = $clog2(refresh_interval + 1);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt         <= '0;
            refresh_due <= 1'b0;
        end else begin
            if (cnt == CNT_W'(refresh_interval)) begin
                cnt         <= '0;
                refresh_due <= 1'b1;  // sticky until acked
            end else begin
                cnt <= cnt + 1'b1;
                if (refresh_ack) refresh_due <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/request_queue.sv
`timescale 1ns/1ps
`default_nettype none

module request_queue (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               in_valid,
    input  wire logic               rw,
    input  wire ctrl_pkg::user_addr_t user_addr,
    input  wire sdram_pkg::word_t   data_in,
    input  wire logic               take_req,
    output logic                    busy,
    output logic                    req_pending,
    output logic                    req_rw,
    output ctrl_pkg::mem_addr_t     req_addr,
    output sdram_pkg::word_t        req_data
);

    logic full;  // one entry held

    sdram_pkg::row_t  map_row;
    sdram_pkg::bank_t map_bank;
    sdram_pkg::col_t  map_col;

    // spread neighbouring user addresses over the banks
    assign map_row  = user_addr[22:10];
    assign map_bank = user_addr[8:7];
    assign map_col  = {user_addr[9], user_addr[6:0]};

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (in_valid && !full) begin
            full <= 1'b1;
        end else if (take_req) begin
            full <= 1'b0;
        end
    end

    // payload, loaded only into an empty slot
    always_ff @(posedge clk) begin
        if (in_valid && !full) begin
            req_rw   <= rw;
            req_addr <= {map_row, map_bank, map_col};
            req_data <= data_in;
        end
    end

    assign busy        = full;
    assign req_pending = full;

endmodule

`default_nettype wire

// File: design/sdram_cmd_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_cmd_fsm #(
    parameter int read_delay = 4
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                req_pending,
    input  wire logic                req_rw,
    input  wire ctrl_pkg::mem_addr_t req_addr,
    input  wire sdram_pkg::word_t    req_data,
    output logic                     take_req,
    input  wire logic                refresh_due,
    output logic                     refresh_ack,
    output sdram_pkg::bank_t         query_bank,
    output sdram_pkg::row_t          query_row,
    input  wire logic                row_open,
    input  wire logic                row_hit,
    output logic                     act_stb,
    output sdram_pkg::bank_t         act_bank,
    output sdram_pkg::row_t          act_row,
    output logic                     pre_stb,
    output sdram_pkg::bank_t         pre_bank,
    output logic                     pre_all,
    output ctrl_pkg::mem_addr_t      look_addr,
    input  wire logic                buf_hit,
    input  wire sdram_pkg::word_t    buf_word,
    output logic                     line_start,
    output ctrl_pkg::line_tag_t      line_tag,
    output logic                     fill_stb,
    output ctrl_pkg::line_idx_t      fill_idx,
    output sdram_pkg::word_t         fill_word,
    output logic                     line_done,
    output logic                     inval,
    output sdram_pkg::word_t         data_out,
    output logic                     out_valid,
    output logic                     sdram_cle,
    output logic                     sdram_cs,
    output logic                     sdram_ras,
    output logic                     sdram_cas,
    output logic                     sdram_we,
    output sdram_pkg::bank_t         sdram_ba,
    output sdram_pkg::pin_addr_t     sdram_a,
    output sdram_pkg::word_t         sdram_dqo,
    input  wire sdram_pkg::word_t    sdram_dqi
);

    ctrl_pkg::ctrl_state_t state_q, state_d, next_q, next_d;
    logic [2:0]            wait_cnt, wait_d;
    logic                  pre_all_q, pre_all_d;

    ctrl_pkg::mem_addr_t   addr_q;  // request in service
    logic                  rw_q;
    sdram_pkg::word_t      wdata_q;

    logic [3:0]            rd_step;  // column reads issued so far
    logic                  issue;
    logic                  last_fill;
    sdram_pkg::col_t       rd_col;
    logic [read_delay-1:0] rd_vld;
    ctrl_pkg::line_idx_t   rd_idx [read_delay];

    sdram_pkg::sdram_cmd_t cmd_q, cmd_d;
    sdram_pkg::bank_t      ba_d;
    sdram_pkg::pin_addr_t  a_d;
    sdram_pkg::word_t      dqo_d, dqi_q, dout_d;
    logic                  ov_d;

    // lookups use the queue head while idle, the held request otherwise
    assign query_bank = req_addr[9:8];
    assign query_row  = req_addr[22:10];
    assign look_addr  = (state_q == ctrl_pkg::IDLE) ? req_addr : addr_q;

    assign act_bank  = addr_q[9:8];
    assign act_row   = addr_q[22:10];
    assign pre_bank  = addr_q[9:8];
    assign line_tag  = addr_q[22:3];
    assign rd_col    = {addr_q[7:3], rd_step[2:0]};

    assign fill_stb  = rd_vld[read_delay-1];
    assign fill_idx  = rd_idx[read_delay-1];
    assign fill_word = dqi_q;
    assign last_fill = fill_stb && (fill_idx == ctrl_pkg::line_idx_t'(ctrl_pkg::LINE_WORDS - 1));

    always_comb begin
        state_d = state_q;
        next_d = next_q;
        wait_d = wait_cnt;
        pre_all_d = pre_all_q;
        cmd_d = sdram_pkg::NOP;
        ba_d = addr_q[9:8];
        a_d = '0;
        dqo_d = sdram_dqo;
        ov_d = 1'b0;
        dout_d = buf_word;
        take_req = 1'b0;
        refresh_ack = 1'b0;
        act_stb = 1'b0;
        pre_stb = 1'b0;
        pre_all = 1'b0;
        line_start = 1'b0;
        line_done = 1'b0;
        inval = 1'b0;
        issue = 1'b0;
        case (state_q)
            ctrl_pkg::IDLE: begin
                if (refresh_due) begin
                    refresh_ack = 1'b1;
                    pre_all_d = 1'b1;
                    next_d = ctrl_pkg::REFRESH;
                    state_d = ctrl_pkg::PRECHARGE;
                end else if (req_pending && !out_valid) begin  // keeps out_valid to 1 cycle
                    take_req = 1'b1;
                    if (!req_rw && buf_hit) begin
                        ov_d = 1'b1;  // answered from the line
                    end else begin
                        inval = req_rw;
                        if (row_hit) begin
                            state_d = req_rw ? ctrl_pkg::WRITE : ctrl_pkg::READ;
                        end else if (row_open) begin  // other row open in this bank
                            pre_all_d = 1'b0;
                            next_d = ctrl_pkg::ACTIVATE;
                            state_d = ctrl_pkg::PRECHARGE;
                        end else begin
                            state_d = ctrl_pkg::ACTIVATE;
                        end
                    end
                end
            end
            ctrl_pkg::WAIT: begin
                wait_d = wait_cnt - 1'b1;
                if (wait_cnt == 3'd1) state_d = next_q;
            end
            ctrl_pkg::PRECHARGE: begin
                cmd_d = sdram_pkg::PRECHARGE;
                a_d[10] = pre_all_q;
                pre_all = pre_all_q;
                pre_stb = !pre_all_q;
                wait_d = 3'(sdram_pkg::T_PRE);
                state_d = ctrl_pkg::WAIT;
            end
            ctrl_pkg::REFRESH: begin
                cmd_d = sdram_pkg::REFRESH;
                wait_d = 3'(sdram_pkg::T_REF);
                next_d = ctrl_pkg::IDLE;
                state_d = ctrl_pkg::WAIT;
            end
            ctrl_pkg::ACTIVATE: begin
                cmd_d = sdram_pkg::ACTIVE;
                a_d = addr_q[22:10];
                act_stb = 1'b1;
                wait_d = 3'(sdram_pkg::T_ACT);
                next_d = rw_q ? ctrl_pkg::WRITE : ctrl_pkg::READ;
                state_d = ctrl_pkg::WAIT;
            end
            ctrl_pkg::READ: begin
                if (rd_step < 4'(ctrl_pkg::LINE_WORDS)) begin
                    issue = 1'b1;
                    cmd_d = sdram_pkg::READ;
                    a_d = {3'b000, rd_col, 2'b00};
                    line_start = (rd_step == 4'd0);
                end
                if (last_fill) begin
                    line_done = 1'b1;
                    ov_d = 1'b1;
                    // requested word may be the one landing right now
                    dout_d = (fill_idx == addr_q[2:0]) ? fill_word : buf_word;
                    state_d = ctrl_pkg::IDLE;
                end
            end
            ctrl_pkg::WRITE: begin
                cmd_d = sdram_pkg::WRITE;
                a_d = {3'b000, addr_q[7:0], 2'b00};
                dqo_d = wdata_q;  // data rides with the command
                state_d = ctrl_pkg::IDLE;
            end
            default: state_d = ctrl_pkg::IDLE;
        endcase
    end

    ////////////////////
    // control state

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ctrl_pkg::IDLE;
            next_q <= ctrl_pkg::IDLE;
            wait_cnt <= '0;
            pre_all_q <= 1'b0;
            rd_step <= '0;
            rd_vld <= '0;
            out_valid <= 1'b0;
            cmd_q <= sdram_pkg::NOP;
            sdram_cle <= 1'b0;
        end else begin
            state_q <= state_d;
            next_q <= next_d;
            wait_cnt <= wait_d;
            pre_all_q <= pre_all_d;
            rd_step <= issue ? rd_step + 1'b1 : (state_q == ctrl_pkg::READ ? rd_step : 4'd0);
            rd_vld <= {rd_vld[read_delay-2:0], issue};
            out_valid <= ov_d;
            cmd_q <= cmd_d;
            sdram_cle <= 1'b1;
        end
    end

    ////////////////////
    // payload and pins

    always_ff @(posedge clk) begin
        if (take_req) begin
            addr_q <= req_addr;
            rw_q <= req_rw;
            wdata_q <= req_data;
        end
        rd_idx[0] <= rd_step[2:0];
        for (int i = 1; i < read_delay; i++) begin
            rd_idx[i] <= rd_idx[i-1];  // word index follows its read
        end
        if (ov_d) data_out <= dout_d;
        sdram_ba <= ba_d;
        sdram_a <= a_d;
        sdram_dqo <= dqo_d;
        dqi_q <= sdram_dqi;
    end

    assign sdram_cs  = cmd_q[3];
    assign sdram_ras = cmd_q[2];
    assign sdram_cas = cmd_q[1];
    assign sdram_we  = cmd_q[0];

endmodule

`default_nettype wire

// File: design/sdram_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_ctrl_top #(
    parameter int refresh_interval = 750,
    parameter int read_delay       = sdram_pkg::CAS_LATENCY + 2  // pin and dqi registers
) (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 in_valid,
    input  wire logic                 rw,
    input  wire ctrl_pkg::user_addr_t user_addr,
    input  wire sdram_pkg::word_t     data_in,
    output logic                      busy,
    output sdram_pkg::word_t          data_out,
    output logic                      out_valid,
    output logic                      sdram_cle,
    output logic                      sdram_cs,
    output logic                      sdram_ras,
    output logic                      sdram_cas,
    output logic                      sdram_we,
    output sdram_pkg::bank_t          sdram_ba,
    output sdram_pkg::pin_addr_t      sdram_a,
    output sdram_pkg::word_t          sdram_dqo,
    input  wire sdram_pkg::word_t     sdram_dqi
);

    // queue to fsm
    logic                req_pending, req_rw, take_req;
    ctrl_pkg::mem_addr_t req_addr;
    sdram_pkg::word_t    req_data;

    logic refresh_due, refresh_ack;

    // bank table
    sdram_pkg::bank_t query_bank, act_bank, pre_bank;
    sdram_pkg::row_t  query_row, act_row;
    logic             row_open, row_hit, act_stb, pre_stb, pre_all;

    // prefetch line
    ctrl_pkg::mem_addr_t look_addr;
    ctrl_pkg::line_tag_t line_tag;
    ctrl_pkg::line_idx_t fill_idx;
    sdram_pkg::word_t    buf_word, fill_word;
    logic                buf_hit, line_start, fill_stb, line_done, inval;

    request_queue queue0 (
        .clk, .rst, .in_valid, .rw, .user_addr, .data_in, .take_req,
        .busy, .req_pending, .req_rw, .req_addr, .req_data
    );

    refresh_timer #(.refresh_interval(refresh_interval)) refresh0 (
        .clk, .rst, .refresh_ack, .refresh_due
    );

    bank_tracker banks0 (
        .clk, .rst, .query_bank, .query_row, .row_open, .row_hit,
        .act_stb, .act_bank, .act_row, .pre_stb, .pre_bank, .pre_all
    );

    prefetch_buffer buffer0 (
        .clk, .rst, .look_addr, .buf_hit, .buf_word, .line_start, .line_tag,
        .fill_stb, .fill_idx, .fill_word, .line_done, .inval
    );

    sdram_cmd_fsm #(.read_delay(read_delay)) fsm0 (
        .clk, .rst, .req_pending, .req_rw, .req_addr, .req_data, .take_req,
        .refresh_due, .refresh_ack,
        .query_bank, .query_row, .row_open, .row_hit,
        .act_stb, .act_bank, .act_row, .pre_stb, .pre_bank, .pre_all,
        .look_addr, .buf_hit, .buf_word, .line_start, .line_tag,
        .fill_stb, .fill_idx, .fill_word, .line_done, .inval,
        .data_out, .out_valid,
        .sdram_cle, .sdram_cs, .sdram_ras, .sdram_cas, .sdram_we,
        .sdram_ba, .sdram_a, .sdram_dqo, .sdram_dqi
    );

endmodule

`default_nettype wire

// File: design/sdram_pkg.sv
`default_nettype none

package sdram_pkg;

    ////////////////////
    // device commands

    // {cs, ras, cas, we} as seen on the pins
    typedef enum logic [3:0] {
        NOP       = 4'b0111,
        ACTIVE    = 4'b0011,
        READ      = 4'b0101,
        WRITE     = 4'b0100,
        PRECHARGE = 4'b0010,
        REFRESH   = 4'b0001
    } sdram_cmd_t;

    ////////////////////
    // device-side widths

    typedef logic [1:0]  bank_t;
    typedef logic [12:0] row_t;
    typedef logic [7:0]  col_t;
    typedef logic [12:0] pin_addr_t;
    typedef logic [31:0] word_t;

    ////////////////////
    // timing

    // cycles spent in WAIT, so the next command lands one cycle later
    localparam int T_ACT = 2;
    localparam int T_PRE = 2;
    localparam int T_REF = 6;

    localparam int CAS_LATENCY = 2; // READ on pins to word on dqi

endpackage

`default_nettype wire

// File: files.f
design/sdram_pkg.sv
design/ctrl_pkg.sv
design/request_queue.sv
design/refresh_timer.sv
design/bank_tracker.sv
design/prefetch_buffer.sv
design/sdram_cmd_fsm.sv
design/sdram_ctrl_top.sv
test/sdram_model.sv
test/sdram_ctrl_chk.sv
test/tb_sdram_ctrl.sv

// File: test/sdram_ctrl_chk.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_ctrl_chk (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 out_valid,
    input  wire logic                 sdram_cs,
    input  wire logic                 sdram_ras,
    input  wire logic                 sdram_cas,
    input  wire logic                 sdram_we,
    input  wire sdram_pkg::bank_t     sdram_ba,
    input  wire sdram_pkg::pin_addr_t sdram_a
);

    sdram_pkg::sdram_cmd_t cmd;
    logic                  is_act, is_rw;
    logic [3:0]            since_act;  // saturating
    logic [3:0]            bank_open;

    assign cmd    = sdram_pkg::sdram_cmd_t'({sdram_cs, sdram_ras, sdram_cas, sdram_we});
    assign is_act = (cmd == sdram_pkg::ACTIVE);
    assign is_rw  = (cmd == sdram_pkg::READ) || (cmd == sdram_pkg::WRITE);

    always_ff @(posedge clk) begin
        if (rst) begin
            since_act <= '1;
            bank_open <= '0;
        end else begin
            if (is_act) begin
                since_act <= 4'd1;
                bank_open[sdram_ba] <= 1'b1;
            end else begin
                if (since_act != '1) since_act <= since_act + 4'd1;
                if (cmd == sdram_pkg::PRECHARGE) begin
                    if (sdram_a[10]) begin
                        bank_open <= '0;  // precharge all
                    end else begin
                        bank_open[sdram_ba] <= 1'b0;
                    end
                end
            end
        end
    end

    out_valid_single: assert property (@(posedge clk) disable iff (rst)
        out_valid |=> !out_valid)
        else $error("out_valid high on two consecutive cycles");

    act_to_col: assert property (@(posedge clk) disable iff (rst)
        is_rw |-> since_act > sdram_pkg::T_ACT)
        else $error("READ or WRITE too close to ACTIVE");

    act_after_pre: assert property (@(posedge clk) disable iff (rst)
        is_act |-> !bank_open[sdram_ba])
        else $error("ACTIVE to a bank that was not precharged");

endmodule

bind sdram_ctrl_top sdram_ctrl_chk chk0 (
    .clk, .rst, .out_valid,
    .sdram_cs, .sdram_ras, .sdram_cas, .sdram_we, .sdram_ba, .sdram_a
);

`default_nettype wire

// File: test/sdram_model.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_model (
    input  wire logic                 clk,
    input  wire logic                 cs,
    input  wire logic                 ras,
    input  wire logic                 cas,
    input  wire logic                 we,
    input  wire sdram_pkg::bank_t     ba,
    input  wire sdram_pkg::pin_addr_t a,
    input  wire sdram_pkg::word_t     dq_in,
    output sdram_pkg::word_t          dq_out
);

    sdram_pkg::sdram_cmd_t cmd;
    logic [22:0]           key;  // {bank, row, col}
    sdram_pkg::row_t       open_row [4];
    sdram_pkg::word_t      mem [logic [22:0]];
    sdram_pkg::word_t      pipe [sdram_pkg::CAS_LATENCY] = '{default: '0};

    assign cmd = sdram_pkg::sdram_cmd_t'({cs, ras, cas, we});
    assign key = {ba, open_row[ba], a[9:2]};

    // never written words come back as a pattern of the whole address
    function automatic sdram_pkg::word_t stored_word(input logic [22:0] k);
        if (mem.exists(k)) return mem[k];
        return {k[8:0], k} ^ 32'hc3c3_c3c3;
    endfunction

    always @(posedge clk) begin
        if (cmd == sdram_pkg::ACTIVE) open_row[ba] <= a;
        if (cmd == sdram_pkg::WRITE) mem[key] = dq_in;  // data rides with the command
        pipe[0] <= (cmd == sdram_pkg::READ) ? stored_word(key) : '0;
        for (int i = 1; i < sdram_pkg::CAS_LATENCY; i++) begin
            pipe[i] <= pipe[i-1];
        end
    end

    assign dq_out = pipe[sdram_pkg::CAS_LATENCY-1];

endmodule

`default_nettype wire

// File: test/tb_sdram_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sdram_ctrl;

    localparam int REFRESH_INTERVAL = 750;
    localparam int IDLE_RUN         = 3000;
    localparam int MAX_OPS          = 100;
    localparam int OP_CYCLES        = 170;  // refresh, conflict and line fetch, with margin
    localparam int TIMEOUT_CYCLES   = IDLE_RUN + MAX_OPS * OP_CYCLES;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 in_valid, rw;
    ctrl_pkg::user_addr_t user_addr;
    sdram_pkg::word_t     data_in, data_out;
    logic                 busy, out_valid;
    logic                 sdram_cle, sdram_cs, sdram_ras, sdram_cas, sdram_we;
    sdram_pkg::bank_t     sdram_ba;
    sdram_pkg::pin_addr_t sdram_a;
    sdram_pkg::word_t     sdram_dqo, sdram_dqi;

    sdram_pkg::sdram_cmd_t pin_cmd;
    sdram_pkg::bank_t      act_ba;
    sdram_pkg::pin_addr_t  act_a, wr_a;
    int                    cycles = 0;
    int                    read_cmds = 0;
    int                    write_cmds = 0;
    int                    refresh_cmds = 0;
    logic                  pre_all_seen = 1'b0;
    logic [15:0]           lfsr = 16'd3;
    string                 test_name = "none";
    sdram_pkg::word_t      ref_mem [ctrl_pkg::user_addr_t];  // expected contents

    always #2 clk = ~clk;

    sdram_ctrl_top #(.refresh_interval(REFRESH_INTERVAL)) dut0 (
        .clk, .rst, .in_valid, .rw, .user_addr, .data_in, .busy, .data_out, .out_valid,
        .sdram_cle, .sdram_cs, .sdram_ras, .sdram_cas, .sdram_we,
        .sdram_ba, .sdram_a, .sdram_dqo, .sdram_dqi
    );

    sdram_model mem0 (
        .clk, .cs(sdram_cs), .ras(sdram_ras), .cas(sdram_cas), .we(sdram_we),
        .ba(sdram_ba), .a(sdram_a), .dq_in(sdram_dqo), .dq_out(sdram_dqi)
    );

    assign pin_cmd = sdram_pkg::sdram_cmd_t'({sdram_cs, sdram_ras, sdram_cas, sdram_we});

    ////////////////////
    // reporting

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input sdram_pkg::word_t expected, input sdram_pkg::word_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("FAILED %s: expected %h, actual %h", test_name, expected, actual));
        end
    endtask

    task automatic check_addr(input sdram_pkg::pin_addr_t expected,
                              input sdram_pkg::pin_addr_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("FAILED %s: expected %h, actual %h", test_name, expected, actual));
        end
    endtask

    // pin monitor and watchdog
    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) abort_run($sformatf("timeout after %0d cycles", cycles));
        if (!rst) begin
            case (pin_cmd)
                sdram_pkg::ACTIVE: begin
                    act_ba = sdram_ba;
                    act_a = sdram_a;
                end
                sdram_pkg::READ: read_cmds++;
                sdram_pkg::WRITE: begin
                    write_cmds++;
                    wr_a = sdram_a;
                end
                sdram_pkg::PRECHARGE: if (sdram_a[10]) pre_all_seen = 1'b1;
                sdram_pkg::REFRESH: begin
                    if (!pre_all_seen) abort_run("REFRESH issued without a precharge all before it");
                    pre_all_seen = 1'b0;
                    refresh_cmds++;
                end
                default: ;
            endcase
        end
    end

    // 16 bit fibonacci lfsr, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    ////////////////////
    // request helpers

    task automatic send_req(input logic is_write, input ctrl_pkg::user_addr_t addr,
                            input sdram_pkg::word_t data);
        while (busy) @(negedge clk);
        in_valid = 1'b1;
        rw = is_write;
        user_addr = addr;
        data_in = data;
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic wait_response(output sdram_pkg::word_t got);
        while (!out_valid) @(negedge clk);
        got = data_out;
    endtask

    task automatic write_word(input ctrl_pkg::user_addr_t addr, input sdram_pkg::word_t data);
        send_req(1'b1, addr, data);
        ref_mem[addr] = data;
    endtask

    task automatic read_check(input ctrl_pkg::user_addr_t addr);
        sdram_pkg::word_t got;
        send_req(1'b0, addr, '0);
        wait_response(got);
        check_word(ref_mem[addr], got);
    endtask

    ////////////////////
    // tests

    task automatic check_reset_state;
        test_name = "reset";
        if (busy || out_valid) abort_run("busy or out_valid high after reset");
        if (pin_cmd != sdram_pkg::NOP) abort_run("command after reset is not NOP");
        if (!sdram_cle) abort_run("sdram_cle low after reset");
    endtask

    task automatic test_write_read;
        ctrl_pkg::user_addr_t base, same_row, other_row;
        ctrl_pkg::user_addr_t addrs [8];
        test_name = "write_read";
        base = ctrl_pkg::user_addr_t'(rand_bits(23));
        same_row = base ^ 23'h000210;   // other column, same bank and row
        other_row = base ^ 23'h000c00;  // same bank, conflicting row
        write_word(base, rand_bits(32));  // bank still closed
        read_check(base);
        write_word(same_row, rand_bits(32));
        read_check(same_row);
        write_word(other_row, rand_bits(32));
        read_check(other_row);
        read_check(base);
        for (int i = 0; i < 8; i++) begin
            addrs[i] = ctrl_pkg::user_addr_t'(rand_bits(23));
            write_word(addrs[i], rand_bits(32));
        end
        for (int i = 0; i < 8; i++) begin
            read_check(addrs[i]);
        end
    endtask

    task automatic test_remap;
        ctrl_pkg::user_addr_t u1, u2;
        int                   writes_before;
        test_name = "remap";
        u1 = ctrl_pkg::user_addr_t'(rand_bits(23));
        u2 = u1 ^ 23'h400000;  // forces precharge and ACTIVE
        write_word(u1, rand_bits(32));
        writes_before = write_cmds + 1;
        write_word(u2, rand_bits(32));
        while (write_cmds <= writes_before) @(negedge clk);
        check_addr(sdram_pkg::pin_addr_t'(u2[22:10]), act_a);
        check_addr(sdram_pkg::pin_addr_t'(u2[8:7]), sdram_pkg::pin_addr_t'(act_ba));
        check_addr({3'b000, u2[9], u2[6:0], 2'b00}, wr_a);
    endtask

    task automatic test_prefetch;
        ctrl_pkg::user_addr_t base;
        int                   reads_before;
        test_name = "prefetch";
        base = {20'(rand_bits(20)), 3'b000};
        for (int i = 0; i < 8; i++) begin
            write_word(base + ctrl_pkg::user_addr_t'(i), rand_bits(32));
        end
        read_check(base + 23'd5);  // miss, fetches the line
        reads_before = read_cmds;
        for (int i = 0; i < 8; i++) begin
            if (i != 5) read_check(base + ctrl_pkg::user_addr_t'(i));
        end
        if (read_cmds != reads_before) abort_run("READ command issued for a prefetch line hit");
    endtask

    task automatic test_coherence;
        ctrl_pkg::user_addr_t base;
        test_name = "coherence";
        base = {20'(rand_bits(20)), 3'b000};
        write_word(base + 23'd2, rand_bits(32));
        write_word(base + 23'd3, rand_bits(32));
        read_check(base + 23'd2);
        write_word(base + 23'd3, rand_bits(32));  // lands in the fetched line
        read_check(base + 23'd3);
        read_check(base + 23'd2);
    endtask

    task automatic test_refresh;
        int refresh_before;
        test_name = "refresh";
        write_word(ctrl_pkg::user_addr_t'(rand_bits(23)), rand_bits(32));
        refresh_before = refresh_cmds;
        repeat (IDLE_RUN) @(negedge clk);
        if (refresh_cmds - refresh_before < IDLE_RUN / (REFRESH_INTERVAL + 1)) begin
            abort_run("too few REFRESH commands during the idle run");
        end
        foreach (ref_mem[k]) begin
            read_check(k);
        end
    endtask

    task automatic test_busy;
        ctrl_pkg::user_addr_t x, y, z;
        sdram_pkg::word_t     got;
        test_name = "busy";
        x = ctrl_pkg::user_addr_t'(rand_bits(23));
        y = x ^ 23'h000400;
        z = x ^ 23'h000001;
        write_word(x, rand_bits(32));
        write_word(y, rand_bits(32));
        send_req(1'b0, y, '0);  // long read miss
        write_word(z, rand_bits(32));  // waits in the queue
        if (!busy) abort_run("busy low while a request waits in the queue");
        in_valid = 1'b1;  // must be dropped
        rw = 1'b1;
        user_addr = x;
        data_in = ~ref_mem[x];
        @(negedge clk);
        in_valid = 1'b0;
        wait_response(got);
        check_word(ref_mem[y], got);
        read_check(x);
        read_check(z);
    endtask

    initial begin
        rst = 1'b1;
        in_valid = 1'b0;
        rw = 1'b0;
        user_addr = '0;
        data_in = '0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_reset_state();
        test_write_read();
        test_remap();
        test_prefetch();
        test_coherence();
        test_refresh();
        test_busy();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire
